// ==== common/ex_config.svh ====
//**********************************************************************
// width settings for the execute stage, included by the package and
// by the decoded op interface
//**********************************************************************
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

`define XLEN       32  // data word
`define REG_ADDR_W 5   // register index
`define SHAMT_W    5   // shift amount

`endif

// ==== common/ex_pkg.sv ====
//**********************************************************************
// shared types of the execute stage: opcodes, funct3 codes, op class
// and ALU op encodings, data word and register index
//**********************************************************************
`default_nettype none

`include "ex_config.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 meaning depends on the opcode group
    typedef enum logic [2:0] {
        F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_OR, F3_AND
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000, F3_BNE = 3'b001, F3_BLT = 3'b100,
        F3_BGE = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111
    } br_f3_e;

    typedef enum logic [2:0] {
        F3_MEM_B = 3'b000, F3_MEM_H = 3'b001, F3_MEM_W = 3'b010,
        F3_MEM_BU = 3'b100, F3_MEM_HU = 3'b101
    } mem_f3_e;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_LOAD, CLS_STORE
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

endpackage

`default_nettype wire

// ==== common/ex_op_if.sv ====
//**********************************************************************
// decoded instruction, driven by the decoder and read by the ALU,
// branch, load/store and commit units
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

interface ex_op_if
    import ex_pkg::*;
();

    op_class_e            op_class;
    alu_op_e              alu_op;
    logic [2:0]           funct3;
    logic [`SHAMT_W-1:0]  shamt_imm;  // zero for register shifts
    reg_addr_t            rd;
    logic                 rd_we;

    modport decoder (output op_class, alu_op, funct3, shamt_imm, rd, rd_we);
    modport unit    (input  op_class, alu_op, funct3, shamt_imm, rd, rd_we);

endinterface

`default_nettype wire

// ==== hdl/ex_decode.sv ====
//**********************************************************************
// instruction decoder of the execute stage, turns the raw RV32I word
// into op class, ALU op, destination and write enable
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ex_decode
    import ex_pkg::*;
(
    input  word_t  inst_i,
    ex_op_if.decoder op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;  // funct7 zero apart from bit 30

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_base = ({funct7[6], funct7[4:0]} == 6'b0);

    assign op.funct3 = funct3;
    assign op.rd     = inst_i[11:7];
    assign op.rd_we  = (op.op_class == CLS_ALU) || (op.op_class == CLS_JUMP)
                    || (op.op_class == CLS_LOAD);

    always_comb begin
        op.op_class  = CLS_NONE;
        op.alu_op    = ALU_ADD;  // jumps, lui and auipc use the sum
        op.shamt_imm = '0;
        case (opcode_e'(opcode))
            OPC_OP_IMM: begin
                op.op_class = CLS_ALU;
                case (alu_f3_e'(funct3))
                    F3_ADD_SUB: op.alu_op = ALU_ADD;
                    F3_SLT:     op.alu_op = ALU_SLT;
                    F3_SLTU:    op.alu_op = ALU_SLTU;
                    F3_XOR:     op.alu_op = ALU_XOR;
                    F3_OR:      op.alu_op = ALU_OR;
                    F3_AND:     op.alu_op = ALU_AND;
                    F3_SLL: begin
                        op.alu_op    = ALU_SLL;
                        op.shamt_imm = inst_i[24:20];
                        if (!f7_base || funct7[5]) op.op_class = CLS_NONE;
                    end
                    default: begin  // srli / srai
                        op.alu_op    = funct7[5] ? ALU_SRA : ALU_SRL;
                        op.shamt_imm = inst_i[24:20];
                        if (!f7_base) op.op_class = CLS_NONE;
                    end
                endcase
            end
            OPC_OP: begin
                case (alu_f3_e'(funct3))
                    F3_ADD_SUB: op.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:     op.alu_op = ALU_SLL;
                    F3_SLT:     op.alu_op = ALU_SLT;
                    F3_SLTU:    op.alu_op = ALU_SLTU;
                    F3_XOR:     op.alu_op = ALU_XOR;
                    F3_SR:      op.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      op.alu_op = ALU_OR;
                    default:    op.alu_op = ALU_AND;
                endcase
                // bit 30 only legal on add/sub and srl/sra
                if (f7_base && (!funct7[5] || funct3 == F3_ADD_SUB || funct3 == F3_SR)) begin
                    op.op_class = CLS_ALU;
                end
            end
            OPC_LOAD: begin
                if (funct3 inside {F3_MEM_B, F3_MEM_H, F3_MEM_W, F3_MEM_BU, F3_MEM_HU}) begin
                    op.op_class = CLS_LOAD;
                end
            end
            OPC_STORE: begin
                if (funct3 inside {F3_MEM_B, F3_MEM_H, F3_MEM_W}) op.op_class = CLS_STORE;
            end
            OPC_BRANCH: begin
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    op.op_class = CLS_BRANCH;
                end
            end
            OPC_JAL:   op.op_class = CLS_JUMP;
            OPC_JALR:  op.op_class = (funct3 == 3'b000) ? CLS_JUMP : CLS_NONE;
            OPC_LUI,
            OPC_AUIPC: op.op_class = CLS_ALU;
            default:   op.op_class = CLS_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu/ex_alu.sv ====
//**********************************************************************
// integer ALU: arithmetic, logic, shifts and set-less-than, plus the
// compare flags used for branch conditions
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_alu
    import ex_pkg::*;
(
    ex_op_if.unit op,
    input  word_t op1_i,
    input  word_t op2_i,
    input  word_t reg1_i,
    output word_t alu_result_o,
    output logic  lt_o,
    output logic  ltu_o,
    output logic  eq_o
);

    logic [`SHAMT_W-1:0] shamt;

    assign lt_o  = $signed(op1_i) < $signed(op2_i);
    assign ltu_o = op1_i < op2_i;
    assign eq_o  = (op1_i == op2_i);

    // register shifts leave shamt_imm at zero, op2 then holds rs2
    // a zero immediate amount equals op2 low bits as well
    assign shamt = (op.shamt_imm != '0) ? op.shamt_imm : op2_i[`SHAMT_W-1:0];

    always_comb begin
        case (op.alu_op)
            ALU_SUB:  alu_result_o = op1_i - op2_i;
            ALU_SLT:  alu_result_o = word_t'(lt_o);
            ALU_SLTU: alu_result_o = word_t'(ltu_o);
            ALU_XOR:  alu_result_o = op1_i ^ op2_i;
            ALU_OR:   alu_result_o = op1_i | op2_i;
            ALU_AND:  alu_result_o = op1_i & op2_i;
            ALU_SLL:  alu_result_o = reg1_i << shamt;
            ALU_SRL:  alu_result_o = reg1_i >> shamt;
            ALU_SRA:  alu_result_o = word_t'($signed(reg1_i) >>> shamt);  // sign kept
            default:  alu_result_o = op1_i + op2_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ex_branch.sv ====
//**********************************************************************
// branch unit, picks the taken condition from funct3 and forms the
// jump target from the jump operands
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ex_branch
    import ex_pkg::*;
(
    ex_op_if.unit op,
    input  logic  lt_i,
    input  logic  ltu_i,
    input  logic  eq_i,
    input  word_t op1_jump_i,
    input  word_t op2_jump_i,
    output logic  take_o,
    output word_t target_o
);

    logic cond;

    always_comb begin
        case (br_f3_e'(op.funct3))
            F3_BEQ:  cond = eq_i;
            F3_BNE:  cond = !eq_i;
            F3_BLT:  cond = lt_i;
            F3_BGE:  cond = !lt_i;
            F3_BLTU: cond = ltu_i;
            F3_BGEU: cond = !ltu_i;
            default: cond = 1'b0;
        endcase
    end

    assign take_o   = (op.op_class == CLS_JUMP) || ((op.op_class == CLS_BRANCH) && cond);
    assign target_o = op1_jump_i + op2_jump_i;

endmodule

`default_nettype wire

// ==== lsu/ex_lsu.sv ====
//**********************************************************************
// load/store unit: one memory address for read and write, lane
// extraction on loads, read-modify-write merge on stores
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ex_lsu
    import ex_pkg::*;
(
    ex_op_if.unit op,
    input  word_t op1_i,
    input  word_t op2_i,
    input  word_t reg2_i,
    input  word_t mem_rdata_i,
    input  logic  int_assert_i,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    output word_t load_data_o
);

    logic [1:0]  lane;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        is_load;
    logic        is_store;

    assign mem_addr_o = op1_i + op2_i;
    assign lane       = mem_addr_o[1:0];
    assign byte_sel   = mem_rdata_i[{lane, 3'b000} +: 8];
    assign half_sel   = (lane == 2'b00) ? mem_rdata_i[15:0] : mem_rdata_i[31:16];

    assign is_load  = (op.op_class == CLS_LOAD);
    assign is_store = (op.op_class == CLS_STORE);

    // no bus traffic while an interrupt is taken
    assign mem_req_o = (is_load || is_store) && !int_assert_i;
    assign mem_we_o  = is_store && !int_assert_i;

    always_comb begin
        case (mem_f3_e'(op.funct3))
            F3_MEM_B:  load_data_o = {{24{byte_sel[7]}}, byte_sel};
            F3_MEM_H:  load_data_o = {{16{half_sel[15]}}, half_sel};
            F3_MEM_BU: load_data_o = {24'h0, byte_sel};
            F3_MEM_HU: load_data_o = {16'h0, half_sel};
            default:   load_data_o = mem_rdata_i;
        endcase
    end

    always_comb begin
        mem_wdata_o = mem_rdata_i;  // untouched lanes come from the read
        case (mem_f3_e'(op.funct3))
            F3_MEM_B: mem_wdata_o[{lane, 3'b000} +: 8] = reg2_i[7:0];
            F3_MEM_H: begin
                if (lane == 2'b00) mem_wdata_o[15:0] = reg2_i[15:0];
                else mem_wdata_o[31:16] = reg2_i[15:0];
            end
            default:  mem_wdata_o = reg2_i;
        endcase
        if (!is_store) mem_wdata_o = '0;
    end

endmodule

`default_nettype wire

// ==== hdl/ex_commit.sv ====
//**********************************************************************
// commit stage, selects the write-back value, applies the interrupt
// override and registers register-write and jump results for one clk
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ex_commit
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    ex_op_if.unit     op,
    input  word_t     alu_result_i,
    input  word_t     load_data_i,
    input  logic      take_i,
    input  word_t     target_i,
    input  word_t     int_addr_i,
    input  logic      int_assert_i,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output word_t     reg_wdata_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    word_t wdata;

    // jal, jalr, lui and auipc all write the ALU sum
    assign wdata = (op.op_class == CLS_LOAD) ? load_data_i : alu_result_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_we_o    <= 1'b0;
            jump_flag_o <= 1'b0;
        end else begin
            reg_we_o    <= op.rd_we && !int_assert_i;
            jump_flag_o <= take_i || int_assert_i;  // interrupt forces a jump
        end
    end

    always_ff @(posedge clk) begin
        reg_waddr_o <= op.rd;
        reg_wdata_o <= wdata;
        jump_addr_o <= int_assert_i ? int_addr_i : target_i;
    end

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
//**********************************************************************
// execute stage top level for a small RV32I core, memory side is
// combinational, register write and jump come out one clk later
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     inst_i,
    input  word_t     reg1_rdata_i,
    input  word_t     reg2_rdata_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  word_t     op1_jump_i,
    input  word_t     op2_jump_i,
    input  word_t     mem_rdata_i,
    input  logic      int_assert_i,
    input  word_t     int_addr_i,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output word_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output word_t     reg_wdata_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    word_t alu_result;
    word_t load_data;
    word_t target;
    logic  lt, ltu, eq;
    logic  take;

    ex_op_if i_op ();

    ex_decode i_decode (.inst_i(inst_i), .op(i_op.decoder));

    ex_alu i_alu (
        .op(i_op.unit), .op1_i(op1_i), .op2_i(op2_i), .reg1_i(reg1_rdata_i),
        .alu_result_o(alu_result), .lt_o(lt), .ltu_o(ltu), .eq_o(eq)
    );

    ex_branch i_branch (
        .op(i_op.unit), .lt_i(lt), .ltu_i(ltu), .eq_i(eq),
        .op1_jump_i(op1_jump_i), .op2_jump_i(op2_jump_i), .take_o(take), .target_o(target)
    );

    ex_lsu i_lsu (
        .op(i_op.unit), .op1_i(op1_i), .op2_i(op2_i), .reg2_i(reg2_rdata_i),
        .mem_rdata_i(mem_rdata_i), .int_assert_i(int_assert_i),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .load_data_o(load_data)
    );

    ex_commit i_commit (
        .clk(clk), .arst_n_i(arst_n_i), .op(i_op.unit),
        .alu_result_i(alu_result), .load_data_i(load_data), .take_i(take),
        .target_i(target), .int_addr_i(int_addr_i), .int_assert_i(int_assert_i),
        .reg_we_o(reg_we_o), .reg_waddr_o(reg_waddr_o), .reg_wdata_o(reg_wdata_o),
        .jump_flag_o(jump_flag_o), .jump_addr_o(jump_addr_o)
    );

endmodule

`default_nettype wire

// ==== tests/ex_stage_props.sv ====
//**********************************************************************
// concurrent checks of the reset and interrupt rules that are bound
// into the execute stage top level
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ex_stage_props
    import ex_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  int_assert_i,
    input  word_t int_addr_i,
    input  logic  mem_req_o,
    input  logic  mem_we_o,
    input  logic  reg_we_o,
    input  logic  jump_flag_o,
    input  word_t jump_addr_o
);

    int unsigned fail_count = 0;  // failed assertions so far

    outputs_low_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !reg_we_o && !jump_flag_o)
        else begin
            fail_count++;
            $error("write or jump flag high during reset");
        end

    no_memory_on_interrupt: assert property (@(posedge clk)
        int_assert_i |-> !mem_req_o && !mem_we_o)
        else begin
            fail_count++;
            $error("memory access while interrupt asserted");
        end

    // one cycle later the interrupt shows as a forced jump
    interrupt_forces_jump: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(int_assert_i) && $past(arst_n_i)
        |-> !reg_we_o && jump_flag_o && (jump_addr_o == $past(int_addr_i)))
        else begin
            fail_count++;
            $error("interrupt did not force a jump to its address");
        end

endmodule

bind ex_stage ex_stage_props i_ex_stage_props (
    .clk(clk), .arst_n_i(arst_n_i), .int_assert_i(int_assert_i), .int_addr_i(int_addr_i),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .reg_we_o(reg_we_o),
    .jump_flag_o(jump_flag_o), .jump_addr_o(jump_addr_o)
);

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
//**********************************************************************
// testbench for the execute stage with random RV32I instructions, a
// small read-only memory model and a reference model checked each cycle
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;
    localparam int NUM_TESTS  = 2000;
    localparam int TIMEOUT    = (RST_CYCLES + NUM_TESTS + 50) * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      arst_n_i, int_assert_i;
    word_t     inst_i, reg1_rdata_i, reg2_rdata_i, op1_i, op2_i;
    word_t     op1_jump_i, op2_jump_i, mem_rdata_i, int_addr_i;
    logic      mem_req_o, mem_we_o, reg_we_o, jump_flag_o;
    word_t     mem_addr_o, mem_wdata_o, reg_wdata_o, jump_addr_o;
    reg_addr_t reg_waddr_o;

    word_t     mem [16];
    word_t     lcg_state   = 32'd19;
    int        error_count = 0;
    logic      exp_req, exp_mwe, exp_we, exp_jump;  // expected outputs
    word_t     exp_maddr, exp_mwdata, exp_wdata, exp_jaddr;
    reg_addr_t exp_waddr;

    ex_stage i_ex_stage (.*);

    assign mem_rdata_i = mem[mem_addr_o[5:2]];  // same-cycle read

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the test loop finished");
        $display("test failed");
        $finish;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};  // upper bits are the better ones
    endfunction

    function automatic word_t alu_result_of(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t load_extract(word_t w, logic [1:0] lane, logic [2:0] f3);
        logic [7:0]  b8;
        logic [15:0] h16;
        b8  = 8'(w >> (8 * lane));
        h16 = (lane == 2'd0) ? w[15:0] : w[31:16];
        case (f3)
            3'd0:    return {{24{b8[7]}}, b8};
            3'd1:    return {{16{h16[15]}}, h16};
            3'd4:    return {24'b0, b8};
            3'd5:    return {16'b0, h16};
            default: return w;
        endcase
    endfunction

    function automatic word_t store_merge(word_t w, word_t d, logic [1:0] lane, logic [2:0] f3);
        case (f3)
            3'd0:    return (w & ~(32'hff << (8 * lane))) | ((d & 32'hff) << (8 * lane));
            3'd1:    return (lane == 2'd0) ? {w[31:16], d[15:0]} : {d[15:0], w[15:0]};
            default: return d;
        endcase
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            error_count++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_registered();
        check_word("reg_we_o", reg_we_o, exp_we);
        check_word("jump_flag_o", jump_flag_o, exp_jump);
        if (exp_we) begin
            check_word("reg_waddr_o", reg_waddr_o, exp_waddr);
            check_word("reg_wdata_o", reg_wdata_o, exp_wdata);
        end
        if (exp_jump) check_word("jump_addr_o", jump_addr_o, exp_jaddr);
    endtask

    task automatic check_memory();
        check_word("mem_req_o", mem_req_o, exp_req);
        check_word("mem_we_o", mem_we_o, exp_mwe);
        if (exp_req) check_word("mem_addr_o", mem_addr_o, exp_maddr);
        if (exp_mwe) check_word("mem_wdata_o", mem_wdata_o, exp_mwdata);
    endtask

    task automatic drive_next_instruction();
        word_t       rnd;
        word_t       addr;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic        alt;
        int          kind;
        rnd          = next_rand();
        kind         = int'(rnd[27:24]) % 7;
        f3           = rnd[2:0];
        imm          = rnd[19:8];
        rd           = rnd[7:3];
        alt          = rnd[20];
        reg1_rdata_i = next_rand();
        reg2_rdata_i = next_rand();
        op1_i        = reg1_rdata_i;
        op2_i        = reg2_rdata_i;
        op1_jump_i   = next_rand();
        op2_jump_i   = next_rand();
        int_addr_i   = next_rand();
        int_assert_i = (rnd[31:29] == 3'b000);
        exp_req      = 1'b0;
        exp_mwe      = 1'b0;
        exp_we       = 1'b0;
        exp_jump     = 1'b0;
        exp_waddr    = rd;
        exp_jaddr    = op1_jump_i + op2_jump_i;
        case (kind)
            0: begin  // register form
                alt       = alt && (f3 == 3'd0 || f3 == 3'd5);
                inst_i    = {1'b0, alt, 5'b0, rnd[24:15], f3, rd, OPC_OP};
                exp_we    = 1'b1;
                exp_wdata = alu_result_of(f3, alt, op1_i, op2_i);
            end
            1: begin
                alt = alt && (f3 == 3'd5);
                if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = {1'b0, alt, 5'b0};
                op2_i     = {{20{imm[11]}}, imm};
                inst_i    = {imm, rnd[29:25], f3, rd, OPC_OP_IMM};
                exp_we    = 1'b1;
                exp_wdata = alu_result_of(f3, alt, op1_i, op2_i);
            end
            2: begin  // lui / auipc
                inst_i    = {rnd[31:12], rd, alt ? OPC_LUI : OPC_AUIPC};
                exp_we    = 1'b1;
                exp_wdata = op1_i + op2_i;
            end
            3: begin
                f3 = f3[2] ? f3 : {2'b00, f3[0]};
                if (alt) op2_i = op1_i;  // reach the equal case often
                inst_i   = {rnd[31:15], f3, rnd[11:7], OPC_BRANCH};
                exp_jump = branch_taken(f3, op1_i, op2_i);
            end
            4: begin  // jal / jalr
                inst_i    = {rnd[31:15], alt ? rnd[14:12] : 3'b000, rd, alt ? OPC_JAL : OPC_JALR};
                exp_we    = 1'b1;
                exp_jump  = 1'b1;
                exp_wdata = op1_i + op2_i;
            end
            5: begin
                if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
                op2_i     = {{20{imm[11]}}, imm};
                addr      = op1_i + op2_i;
                inst_i    = {imm, rnd[29:25], f3, rd, OPC_LOAD};
                exp_we    = 1'b1;
                exp_wdata = load_extract(mem[addr[5:2]], addr[1:0], f3);
                exp_req   = 1'b1;
                exp_maddr = addr;
            end
            default: begin
                f3         = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
                op2_i      = {{20{imm[11]}}, imm};
                addr       = op1_i + op2_i;
                inst_i     = {imm[11:5], rnd[24:20], rnd[29:25], f3, imm[4:0], OPC_STORE};
                exp_req    = 1'b1;
                exp_mwe    = 1'b1;
                exp_maddr  = addr;
                exp_mwdata = store_merge(mem[addr[5:2]], reg2_rdata_i, addr[1:0], f3);
            end
        endcase
        if (int_assert_i) begin  // interrupt wins over everything
            exp_req   = 1'b0;
            exp_mwe   = 1'b0;
            exp_we    = 1'b0;
            exp_jump  = 1'b1;
            exp_jaddr = int_addr_i;
        end
    endtask

    initial begin
        arst_n_i     = 1'b0;
        inst_i       = '0;
        reg1_rdata_i = '0;
        reg2_rdata_i = '0;
        op1_i        = '0;
        op2_i        = '0;
        op1_jump_i   = '0;
        op2_jump_i   = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        for (int i = 0; i < 16; i++) mem[i] = (32'h9e37_79b9 * (i + 1)) ^ (i << 20);
        for (int t = 0; t < RST_CYCLES + NUM_TESTS + 1; t++) begin
            @(negedge clk);
            if (t < RST_CYCLES) begin
                check_word("reg_we_o", reg_we_o, '0);
                check_word("jump_flag_o", jump_flag_o, '0);
            end else if (t > RST_CYCLES) begin
                check_registered();
            end
            if (t == RST_CYCLES) arst_n_i = 1'b1;
            if (t < RST_CYCLES + NUM_TESTS) begin
                drive_next_instruction();
                #(CLK_PERIOD / 4);
                check_memory();
            end
        end
        $display("checks done, %0d testbench errors, %0d property errors", error_count,
                 i_ex_stage.i_ex_stage_props.fail_count);
        if (error_count == 0 && i_ex_stage.i_ex_stage_props.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
+incdir+common
common/ex_pkg.sv
common/ex_op_if.sv
hdl/ex_decode.sv
alu/ex_alu.sv
hdl/ex_branch.sv
lsu/ex_lsu.sv
hdl/ex_commit.sv
hdl/ex_stage.sv
tests/ex_stage_props.sv
tests/tb_ex_stage.sv

// ==== Makefile ====
TOP = tb_ex_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ex_stage.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
